// File: bus_int_params.svh
/*
 * Bus interconnect housekeeping constants
 * Bus widths, settings and readback address maps, reset values and the
 * fixed compatibility and protocol words
 */
`ifndef BUS_INT_PARAMS_SVH
`define BUS_INT_PARAMS_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define BUS_INT_SR_AWIDTH 8
`define BUS_INT_RB_AWIDTH 8
`define BUS_INT_DWIDTH    32

// Settings bus address map
`define BUS_INT_SR_LEDS       8'd0
`define BUS_INT_SR_SW_RST     8'd1
`define BUS_INT_SR_CLOCK_CTRL 8'd2
`define BUS_INT_SR_DEVICE_ID  8'd3
`define BUS_INT_SR_REF_FREQ   8'd4
`define BUS_INT_SR_SFPP_CTRL0 8'd8
`define BUS_INT_SR_SFPP_CTRL1 8'd9

// Readback address map
`define BUS_INT_RB_COUNTER      8'd0
`define BUS_INT_RB_CLK_STATUS   8'd3
`define BUS_INT_RB_COMPAT_NUM   8'd6
`define BUS_INT_RB_RFNOC_INFO   8'd7
`define BUS_INT_RB_SFPP_STATUS0 8'd8
`define BUS_INT_RB_SFPP_STATUS1 8'd9
`define BUS_INT_RB_XADC_VALS    8'd11

// ----------------------------------------------------------
// Fixed words and reset values
// ----------------------------------------------------------
`define BUS_INT_COMPAT_MAJOR 16'h0025
`define BUS_INT_COMPAT_MINOR 16'h0000
`define BUS_INT_PROTOVER     16'h0100

// Bit 6 enables the GPSDO by default
`define BUS_INT_CLOCK_CTRL_RST 8'h40
// 10 MHz reference clock
`define BUS_INT_REF_FREQ_RST   32'd10_000_000

`endif

// File: bus_regs_pkg.sv
/*
 * Register bus types
 * Settings bus, readback request and the bridge state encoding
 */
`include "bus_int_params.svh"

package bus_regs_pkg;

   // ----------------------------------------------------------
   // Address spaces and data
   // ----------------------------------------------------------
   typedef logic [`BUS_INT_SR_AWIDTH-1:0] sr_addr_t;
   typedef logic [`BUS_INT_RB_AWIDTH-1:0] rb_addr_t;
   typedef logic [`BUS_INT_DWIDTH-1:0]    bus_word_t;

   // Carried in the RFNoC info readback
   typedef logic [15:0] device_id_t;

   // ----------------------------------------------------------
   // Bus structures
   // ----------------------------------------------------------

   // Settings write, valid for one cycle with stb
   typedef struct packed {
      logic      stb;
      sr_addr_t  addr;
      bus_word_t data;
   } set_bus_t;

   // Readback request, data comes back combinationally
   typedef struct packed {
      logic     rd_stb;
      rb_addr_t addr;
   } rb_req_t;

   // Wishbone bridge FSM
   typedef enum logic {
      idle,
      ack
   } wb_state_t;

endpackage

// File: sfp_pkg.sv
/*
 * SFP cage types
 * Module pins, PHY status, rate select drives and the status word
 */
package sfp_pkg;

   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   typedef logic [15:0] phy_status_t;

   // Bit 0 pulls rs0 low, bit 1 pulls rs1 low
   typedef logic [1:0] sfp_rs_t;

   // Readback layout, MSB first
   typedef struct packed {
      phy_status_t phy;
      logic [9:0]  zero;
      sfp_pins_t   changed;
      sfp_pins_t   current;
   } sfp_status_t;

endpackage

// File: wb_settings_bridge.sv
/*
 * Wishbone classic slave bridge
 * Accepts one access at a time, sends writes onto the settings bus and
 * reads onto the readback request, and acks one cycle later
 */
`timescale 1ns/10ps

module wb_settings_bridge (
   input  logic                    clk,
   input  logic                    i_arst_n,
   input  logic                    i_wb_cyc,
   input  logic                    i_wb_stb,
   input  logic                    i_wb_we,
   input  bus_regs_pkg::sr_addr_t  i_wb_adr,
   input  bus_regs_pkg::bus_word_t i_wb_dat,
   output logic                    o_wb_ack,
   output bus_regs_pkg::bus_word_t o_wb_dat,
   output bus_regs_pkg::set_bus_t  o_set,
   output bus_regs_pkg::rb_req_t   o_rb_req,
   input  bus_regs_pkg::bus_word_t i_rb_data
);

   bus_regs_pkg::wb_state_t state;
   logic                    accept;

   // New access only from idle, master holds stb until ack
   assign accept = i_wb_cyc && i_wb_stb && (state == bus_regs_pkg::idle);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= bus_regs_pkg::idle;
      end else begin
         case (state)
            bus_regs_pkg::idle: begin
               if (accept) begin
                  state <= bus_regs_pkg::ack;
               end
            end
            default: begin
               state <= bus_regs_pkg::idle;
            end
         endcase
      end
   end

   assign o_wb_ack = (state == bus_regs_pkg::ack);

   // Read word captured on the accepting edge, valid with ack
   always_ff @(posedge clk) begin
      if (accept && !i_wb_we) begin
         o_wb_dat <= i_rb_data;
      end
   end

   always_comb begin
      o_set.stb       = accept && i_wb_we;
      o_set.addr      = i_wb_adr;
      o_set.data      = i_wb_dat;
      o_rb_req.rd_stb = accept && !i_wb_we;
      o_rb_req.addr   = bus_regs_pkg::rb_addr_t'(i_wb_adr);
   end

   ack_single_cycle: assert property (
      @(posedge clk) disable iff (!i_arst_n) o_wb_ack |=> !o_wb_ack
   ) else $error("wb ack held for more than one cycle");

endmodule

// File: setting_bank.sv
/*
 * Housekeeping control registers
 * Decodes settings bus writes into LEDs, soft resets, clock control,
 * device ID, reference frequency and SFP rate select
 */
`timescale 1ns/10ps
`include "bus_int_params.svh"

module setting_bank (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  bus_regs_pkg::set_bus_t   i_set,
   output logic [1:0]               o_leds,
   output logic [3:0]               o_sw_rst,
   output logic [7:0]               o_clock_control,
   output bus_regs_pkg::device_id_t o_device_id,
   output bus_regs_pkg::bus_word_t  o_ref_freq,
   output logic                     o_ref_freq_changed,
   output sfp_pkg::sfp_rs_t         o_sfp0_rs,
   output sfp_pkg::sfp_rs_t         o_sfp1_rs
);

   // ----------------------------------------------------------
   // Register writes
   // ----------------------------------------------------------

   // Soft reset bits
   //   [0] PHY
   //   [1] radio clock domain
   //   [2] radio clock PLL
   //   [3] ADC IDELAYCTRL
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         o_clock_control <= `BUS_INT_CLOCK_CTRL_RST;
         o_device_id     <= '0;
         o_ref_freq      <= `BUS_INT_REF_FREQ_RST;
         o_sfp0_rs       <= '0;
         o_sfp1_rs       <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            `BUS_INT_SR_LEDS:       o_leds          <= i_set.data[1:0];
            `BUS_INT_SR_SW_RST:     o_sw_rst        <= i_set.data[3:0];
            `BUS_INT_SR_CLOCK_CTRL: o_clock_control <= i_set.data[7:0];
            `BUS_INT_SR_DEVICE_ID:  o_device_id     <= i_set.data[15:0];
            `BUS_INT_SR_REF_FREQ:   o_ref_freq      <= i_set.data;
            // Set bit drives the open-drain pin low
            `BUS_INT_SR_SFPP_CTRL0: o_sfp0_rs       <= i_set.data[1:0];
            `BUS_INT_SR_SFPP_CTRL1: o_sfp1_rs       <= i_set.data[1:0];
            default: begin
            end
         endcase
      end
   end

   // ----------------------------------------------------------
   // Reference frequency change pulse
   // ----------------------------------------------------------

   // Fires on every write, even with unchanged data
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ref_freq_changed <= 1'b0;
      end else begin
         o_ref_freq_changed <= i_set.stb && (i_set.addr == `BUS_INT_SR_REF_FREQ);
      end
   end

   // Bridge never issues back-to-back writes
   ref_freq_pulse: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      o_ref_freq_changed |=> !o_ref_freq_changed
   ) else $error("ref_freq_changed high for two cycles");

endmodule

// File: sfp_status_monitor.sv
/*
 * SFP cage status monitor
 * Synchronizes module pins and PHY status, latches pin changes until
 * the status word is read
 */
`timescale 1ns/10ps

module sfp_status_monitor (
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  sfp_pkg::sfp_pins_t     i_pins,
   input  sfp_pkg::phy_status_t   i_phy_status,
   input  logic                   i_clear,
   output sfp_pkg::sfp_status_t   o_status
);

   sfp_pkg::sfp_pins_t   pins_meta;
   sfp_pkg::sfp_pins_t   pins_sync;
   sfp_pkg::sfp_pins_t   pins_prev;
   sfp_pkg::sfp_pins_t   pins_diff;
   sfp_pkg::sfp_pins_t   changed;
   sfp_pkg::phy_status_t phy_meta;
   sfp_pkg::phy_status_t phy_sync;

   // ----------------------------------------------------------
   // Synchronizers
   // ----------------------------------------------------------

   // Pins start at 0 so no spurious change flags out of reset
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pins_meta <= '0;
         pins_sync <= '0;
         pins_prev <= '0;
      end else begin
         pins_meta <= i_pins;
         pins_sync <= pins_meta;
         pins_prev <= pins_sync;
      end
   end

   // PHY status bits are all independent and asynchronous
   always_ff @(posedge clk) begin
      phy_meta <= i_phy_status;
      phy_sync <= phy_meta;
   end

   // ----------------------------------------------------------
   // Sticky change flags
   // ----------------------------------------------------------
   assign pins_diff = pins_sync ^ pins_prev;

   // A change on the clearing edge still gets recorded
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         changed <= '0;
      end else if (i_clear) begin
         changed <= pins_diff;
      end else begin
         changed <= changed | pins_diff;
      end
   end

   always_comb begin
      o_status.phy     = phy_sync;
      o_status.zero    = '0;
      o_status.changed = changed;
      o_status.current = pins_sync;
   end

endmodule

// File: readback_mux.sv
/*
 * Housekeeping readback multiplexer
 * Free-running bus clock counter and read word selection, with the
 * clear pulses for the SFP status monitors
 */
`timescale 1ns/10ps
`include "bus_int_params.svh"

module readback_mux (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  bus_regs_pkg::rb_req_t    i_rb_req,
   output bus_regs_pkg::bus_word_t  o_rb_data,
   input  bus_regs_pkg::device_id_t i_device_id,
   input  logic [7:0]               i_clock_status,
   input  sfp_pkg::sfp_status_t     i_sfp0_status,
   input  sfp_pkg::sfp_status_t     i_sfp1_status,
   input  bus_regs_pkg::bus_word_t  i_xadc,
   output logic                     o_sfp0_clear,
   output logic                     o_sfp1_clear
);

   bus_regs_pkg::bus_word_t counter;

   // ----------------------------------------------------------
   // Bus clock counter
   // ----------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // ----------------------------------------------------------
   // Read word selection
   // ----------------------------------------------------------
   always_comb begin
      case (i_rb_req.addr)
         `BUS_INT_RB_COUNTER:      o_rb_data = counter;
         `BUS_INT_RB_CLK_STATUS:   o_rb_data = {24'b0, i_clock_status};
         `BUS_INT_RB_COMPAT_NUM: begin
            o_rb_data = {`BUS_INT_COMPAT_MAJOR, `BUS_INT_COMPAT_MINOR};
         end
         `BUS_INT_RB_RFNOC_INFO:   o_rb_data = {i_device_id, `BUS_INT_PROTOVER};
         `BUS_INT_RB_SFPP_STATUS0: o_rb_data = i_sfp0_status;
         `BUS_INT_RB_SFPP_STATUS1: o_rb_data = i_sfp1_status;
         `BUS_INT_RB_XADC_VALS:    o_rb_data = i_xadc;
         default:                  o_rb_data = '0;
      endcase
   end

   // Status read clears on the accepting edge, the word goes out
   // with the flags as they were before
   assign o_sfp0_clear = i_rb_req.rd_stb && (i_rb_req.addr == `BUS_INT_RB_SFPP_STATUS0);
   assign o_sfp1_clear = i_rb_req.rd_stb && (i_rb_req.addr == `BUS_INT_RB_SFPP_STATUS1);

endmodule

// File: bus_int.sv
/*
 * Motherboard bus interconnect housekeeping block
 * Wishbone slave in front of the control registers, readback mux and
 * the two SFP status monitors
 */
`timescale 1ns/10ps

module bus_int (
   input  logic                    clk,
   input  logic                    i_arst_n,
   // Wishbone slave
   input  logic                    i_wb_cyc,
   input  logic                    i_wb_stb,
   input  logic                    i_wb_we,
   input  bus_regs_pkg::sr_addr_t  i_wb_adr,
   input  bus_regs_pkg::bus_word_t i_wb_dat,
   output logic                    o_wb_ack,
   output bus_regs_pkg::bus_word_t o_wb_dat,
   // Control outputs
   output logic [1:0]              o_leds,
   output logic [3:0]              o_sw_rst,
   output logic [7:0]              o_clock_control,
   output bus_regs_pkg::bus_word_t o_ref_freq,
   output logic                    o_ref_freq_changed,
   // Status inputs
   input  logic [7:0]              i_clock_status,
   input  sfp_pkg::sfp_pins_t      i_sfp0_pins,
   input  sfp_pkg::sfp_pins_t      i_sfp1_pins,
   input  sfp_pkg::phy_status_t    i_sfp0_phy_status,
   input  sfp_pkg::phy_status_t    i_sfp1_phy_status,
   input  bus_regs_pkg::bus_word_t i_xadc_readback,
   // SFP rate select drives
   output sfp_pkg::sfp_rs_t        o_sfp0_rs,
   output sfp_pkg::sfp_rs_t        o_sfp1_rs
);

   bus_regs_pkg::set_bus_t   set_bus;
   bus_regs_pkg::rb_req_t    rb_req;
   bus_regs_pkg::bus_word_t  rb_data;
   bus_regs_pkg::device_id_t device_id;
   sfp_pkg::sfp_status_t     sfp0_status;
   sfp_pkg::sfp_status_t     sfp1_status;
   logic                     sfp0_clear;
   logic                     sfp1_clear;

   wb_settings_bridge bridge (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
      .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
      .o_wb_ack(o_wb_ack), .o_wb_dat(o_wb_dat),
      .o_set(set_bus), .o_rb_req(rb_req), .i_rb_data(rb_data)
   );

   setting_bank settings (
      .clk(clk), .i_arst_n(i_arst_n), .i_set(set_bus),
      .o_leds(o_leds), .o_sw_rst(o_sw_rst), .o_clock_control(o_clock_control),
      .o_device_id(device_id), .o_ref_freq(o_ref_freq),
      .o_ref_freq_changed(o_ref_freq_changed),
      .o_sfp0_rs(o_sfp0_rs), .o_sfp1_rs(o_sfp1_rs)
   );

   readback_mux readback (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_rb_req(rb_req), .o_rb_data(rb_data),
      .i_device_id(device_id), .i_clock_status(i_clock_status),
      .i_sfp0_status(sfp0_status), .i_sfp1_status(sfp1_status),
      .i_xadc(i_xadc_readback),
      .o_sfp0_clear(sfp0_clear), .o_sfp1_clear(sfp1_clear)
   );

   // One monitor per SFP+ cage
   sfp_status_monitor sfp0_mon (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_pins(i_sfp0_pins), .i_phy_status(i_sfp0_phy_status),
      .i_clear(sfp0_clear), .o_status(sfp0_status)
   );

   sfp_status_monitor sfp1_mon (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_pins(i_sfp1_pins), .i_phy_status(i_sfp1_phy_status),
      .i_clear(sfp1_clear), .o_status(sfp1_status)
   );

endmodule

// File: bus_int_tb.sv
/*
 * Testbench for the bus interconnect housekeeping block
 * Drives the Wishbone port and status inputs, checks control outputs
 * and read words against a shadow model of the registers
 */
`timescale 1ns/10ps
`include "bus_int_params.svh"

module bus_int_tb;

   localparam int ACK_TIMEOUT  = 20;
   localparam int SYNC_TIMEOUT = 20;
   localparam int POLL_LIMIT   = 10;
   // Every setting address plus one unused address
   localparam logic [7:0] SET_ADDRS [8] = '{
      `BUS_INT_SR_LEDS, `BUS_INT_SR_SW_RST, `BUS_INT_SR_CLOCK_CTRL, `BUS_INT_SR_DEVICE_ID,
      `BUS_INT_SR_REF_FREQ, `BUS_INT_SR_SFPP_CTRL0, `BUS_INT_SR_SFPP_CTRL1, 8'd5
   };

   logic               clk;
   logic               i_arst_n;
   logic               i_wb_cyc;
   logic               i_wb_stb;
   logic               i_wb_we;
   logic [7:0]         i_wb_adr;
   logic [31:0]        i_wb_dat;
   logic               o_wb_ack;
   logic [31:0]        o_wb_dat;
   logic [1:0]         o_leds;
   logic [3:0]         o_sw_rst;
   logic [7:0]         o_clock_control;
   logic [31:0]        o_ref_freq;
   logic               o_ref_freq_changed;
   logic [7:0]         i_clock_status;
   sfp_pkg::sfp_pins_t i_sfp0_pins;
   sfp_pkg::sfp_pins_t i_sfp1_pins;
   logic [15:0]        i_sfp0_phy_status;
   logic [15:0]        i_sfp1_phy_status;
   logic [31:0]        i_xadc_readback;
   logic [1:0]         o_sfp0_rs;
   logic [1:0]         o_sfp1_rs;

   // Shadow register model
   logic [1:0]  sh_leds;
   logic [3:0]  sh_sw_rst;
   logic [7:0]  sh_clock_control;
   logic [15:0] sh_device_id;
   logic [31:0] sh_ref_freq;
   logic [1:0]  sh_sfp0_rs;
   logic [1:0]  sh_sfp1_rs;
   logic [2:0]  sh_changed0;
   logic [2:0]  sh_changed1;

   integer seed;
   int     mismatch_count;
   int     failure_count;
   int     pulse_count;
   int     exp_pulses;
   logic   monitor_on;

   bus_int dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ------------------------------------------------------------
   // Reference model and reporting
   // ------------------------------------------------------------

   // Counter reads are checked by ordering only
   function automatic logic [31:0] expected_read(input logic [7:0] addr);
      case (addr)
         `BUS_INT_RB_CLK_STATUS:   return {24'h0, i_clock_status};
         `BUS_INT_RB_COMPAT_NUM:   return {16'h0025, 16'h0000};
         `BUS_INT_RB_RFNOC_INFO:   return {sh_device_id, 16'h0100};
         `BUS_INT_RB_SFPP_STATUS0: return {i_sfp0_phy_status, 10'h0, sh_changed0, i_sfp0_pins};
         `BUS_INT_RB_SFPP_STATUS1: return {i_sfp1_phy_status, 10'h0, sh_changed1, i_sfp1_pins};
         `BUS_INT_RB_XADC_VALS:    return i_xadc_readback;
         default:                  return 32'h0;
      endcase
   endfunction

   // Shadow follows the DUT at the accepting edge
   task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
      case (addr)
         `BUS_INT_SR_LEDS:       sh_leds          <= data[1:0];
         `BUS_INT_SR_SW_RST:     sh_sw_rst        <= data[3:0];
         `BUS_INT_SR_CLOCK_CTRL: sh_clock_control <= data[7:0];
         `BUS_INT_SR_DEVICE_ID:  sh_device_id     <= data[15:0];
         `BUS_INT_SR_SFPP_CTRL0: sh_sfp0_rs       <= data[1:0];
         `BUS_INT_SR_SFPP_CTRL1: sh_sfp1_rs       <= data[1:0];
         `BUS_INT_SR_REF_FREQ: begin
            sh_ref_freq <= data;
            exp_pulses++;
         end
         default: begin
         end
      endcase
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         mismatch_count++;
         $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      failure_count++;
      $display("error: %s", what);
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   endtask

   // ------------------------------------------------------------
   // Wishbone master
   // ------------------------------------------------------------
   task automatic wb_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      int cycles;
      cycles = 0;
      @(negedge clk);
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = we;
      i_wb_adr = addr;
      i_wb_dat = wdata;
      if (we) begin
         apply_write(addr, wdata);
      end
      @(negedge clk);
      while (!o_wb_ack) begin
         cycles++;
         if (cycles > ACK_TIMEOUT) begin
            report_failure("no Wishbone ack within the timeout");
            finish_run();
         end
         @(negedge clk);
      end
      rdata    = o_wb_dat;
      // Change pulse rides with the ack of a reference frequency write only
      check_value("o_ref_freq_changed", 32'(o_ref_freq_changed),
                  32'(we && addr == `BUS_INT_SR_REF_FREQ));
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
   endtask

   task automatic read_and_check(input logic [7:0] addr, input string name);
      logic [31:0] got;
      wb_access(1'b0, addr, 32'h0, got);
      check_value(name, got, expected_read(addr));
   endtask

   // Poll the monitor until the synchronized pins follow the inputs
   task automatic wait_current(input int mon);
      sfp_pkg::sfp_status_t word;
      sfp_pkg::sfp_pins_t   pins;
      int                   cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         word = (mon == 0) ? dut.sfp0_status : dut.sfp1_status;
         pins = (mon == 0) ? i_sfp0_pins : i_sfp1_pins;
         if (cycles > SYNC_TIMEOUT) begin
            report_failure("SFP pin change never reached the status word");
            finish_run();
         end
      end while (word.current !== pins);
   endtask

   // Control outputs against the shadow on every falling edge
   always @(negedge clk) begin
      if (monitor_on) begin
         check_value("o_leds", 32'(o_leds), 32'(sh_leds));
         check_value("o_sw_rst", 32'(o_sw_rst), 32'(sh_sw_rst));
         check_value("o_clock_control", 32'(o_clock_control), 32'(sh_clock_control));
         check_value("o_ref_freq", o_ref_freq, sh_ref_freq);
         check_value("o_sfp0_rs", 32'(o_sfp0_rs), 32'(sh_sfp0_rs));
         check_value("o_sfp1_rs", 32'(o_sfp1_rs), 32'(sh_sfp1_rs));
         if (o_ref_freq_changed) begin
            pulse_count++;
         end
      end
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      logic [31:0] data;
      logic [31:0] first_count;
      logic [31:0] second_count;
      logic [31:0] exp_word;
      logic [7:0]  addr;
      logic [2:0]  mask;
      int          polls;
      seed = 17232;
      mismatch_count = 0;
      failure_count = 0;
      pulse_count = 0;
      exp_pulses = 0;
      monitor_on = 1'b0;
      i_arst_n = 1'b0;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we = 1'b0;
      i_wb_adr = 8'h0;
      i_wb_dat = 32'h0;
      i_clock_status = 8'h0;
      i_sfp0_pins = '0;
      i_sfp1_pins = '0;
      i_sfp0_phy_status = 16'h0;
      i_sfp1_phy_status = 16'h0;
      i_xadc_readback = 32'h0;
      sh_leds = 2'h0;
      sh_sw_rst = 4'h0;
      sh_clock_control = 8'h40;
      sh_device_id = 16'h0;
      sh_ref_freq = 32'd10_000_000;
      sh_sfp0_rs = 2'h0;
      sh_sfp1_rs = 2'h0;
      sh_changed0 = 3'h0;
      sh_changed1 = 3'h0;
      repeat (16) @(negedge clk);
      i_arst_n = 1'b1;
      @(negedge clk);

      // Reset values
      check_value("o_wb_ack", 32'(o_wb_ack), 32'h0);
      check_value("o_ref_freq_changed", 32'(o_ref_freq_changed), 32'h0);
      check_value("o_clock_control", 32'(o_clock_control), 32'h40);
      check_value("o_ref_freq", o_ref_freq, 32'd10_000_000);
      check_value("o_leds", 32'(o_leds), 32'h0);
      check_value("o_sw_rst", 32'(o_sw_rst), 32'h0);
      check_value("o_sfp0_rs", 32'(o_sfp0_rs), 32'h0);
      check_value("o_sfp1_rs", 32'(o_sfp1_rs), 32'h0);
      monitor_on = 1'b1;

      // Random settings writes
      repeat (3) begin
         for (int i = 0; i < 8; i++) begin
            data = $random(seed);
            wb_access(1'b1, SET_ADDRS[i], data, first_count);
         end
      end
      @(negedge clk);
      check_value("ref_freq_changed pulses", 32'(pulse_count), 32'(exp_pulses));

      // Fixed and input readbacks
      data = $random(seed);
      wb_access(1'b1, `BUS_INT_SR_DEVICE_ID, data, first_count);
      data = $random(seed);
      i_clock_status = data[7:0];
      i_xadc_readback = $random(seed);
      read_and_check(`BUS_INT_RB_COMPAT_NUM, "compat word");
      read_and_check(`BUS_INT_RB_RFNOC_INFO, "rfnoc info");
      read_and_check(`BUS_INT_RB_CLK_STATUS, "clock status");
      read_and_check(`BUS_INT_RB_XADC_VALS, "xadc word");
      read_and_check(8'd5, "unused address");

      wb_access(1'b0, `BUS_INT_RB_COUNTER, 32'h0, first_count);
      wb_access(1'b0, `BUS_INT_RB_COUNTER, 32'h0, second_count);
      if (second_count <= first_count) begin
         report_failure("bus clock counter did not advance between two reads");
      end

      // Pin change flags on one monitor at a time
      for (int mon = 0; mon < 2; mon++) begin
         data = $random(seed);
         mask = 3'b001 << (data[7:0] % 3);
         if (mon == 0) begin
            i_sfp0_pins = i_sfp0_pins ^ mask;
         end else begin
            i_sfp1_pins = i_sfp1_pins ^ mask;
         end
         wait_current(mon);
         // Changed bit sets one cycle after current and before the read is accepted
         if (mon == 0) begin
            sh_changed0 = mask;
         end else begin
            sh_changed1 = mask;
         end
         addr = (mon == 0) ? `BUS_INT_RB_SFPP_STATUS0 : `BUS_INT_RB_SFPP_STATUS1;
         read_and_check(addr, "status with change flag");
         sh_changed0 = 3'h0;
         sh_changed1 = 3'h0;
         read_and_check(addr, "status after clear");
         addr = (mon == 0) ? `BUS_INT_RB_SFPP_STATUS1 : `BUS_INT_RB_SFPP_STATUS0;
         read_and_check(addr, "other monitor status");
      end

      // PHY status through the synchronizer
      data = $random(seed);
      i_sfp0_phy_status = data[15:0];
      i_sfp1_phy_status = data[31:16];
      for (int mon = 0; mon < 2; mon++) begin
         addr = (mon == 0) ? `BUS_INT_RB_SFPP_STATUS0 : `BUS_INT_RB_SFPP_STATUS1;
         exp_word = expected_read(addr);
         polls = 0;
         do begin
            wb_access(1'b0, addr, 32'h0, data);
            polls++;
            if (polls > POLL_LIMIT) begin
               report_failure("PHY status never reached the status word");
               finish_run();
            end
         end while (data[31:16] !== exp_word[31:16]);
         read_and_check(addr, "status with PHY bits");
      end

      finish_run();
   end

endmodule

// File: bus_int.f
+incdir+.
bus_regs_pkg.sv
sfp_pkg.sv
wb_settings_bridge.sv
setting_bank.sv
sfp_status_monitor.sv
readback_mux.sv
bus_int.sv
bus_int_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the bus_int testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f bus_int.f --top-module bus_int_tb -o bus_int_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_output=$(./obj_dir/bus_int_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
